// ==== filelist.f ====
+incdir+hw
hw/soc_pkg.sv
hw/mem_bus_if.sv
hw/bus_arbiter.sv
hw/addr_router.sv
hw/clint_timer.sv
hw/ram_bridge.sv
hw/soc_top.sv
test/tb_soc_top.sv

// ==== hw/addr_router.sv ====
// address router for the system bus
// exact mtime or mtimecmp hits go to the timer, the rest to RAM
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module addr_router import soc_pkg::*; (
    input  wire logic clk,
    input  wire logic i_reset,
    mem_bus_if.slave  sys_bus,
    mem_bus_if.master timer_bus,
    mem_bus_if.master ram_bus
);

    slave_sel_e req_sel;
    slave_sel_e sel_q;
    logic       busy_q;

    always_comb begin
        if (sys_bus.req_addr == `SOC_MTIME_ADDR || sys_bus.req_addr == `SOC_MTIMECMP_ADDR) begin
            req_sel = SEL_TIMER;
        end else begin
            req_sel = SEL_RAM;
        end
    end

    // payload fans out, valid only to the chosen slave
    assign timer_bus.req_valid = sys_bus.req_valid && !busy_q && (req_sel == SEL_TIMER);
    assign timer_bus.req_addr  = sys_bus.req_addr;
    assign timer_bus.req_wdata = sys_bus.req_wdata;
    assign timer_bus.req_we    = sys_bus.req_we;

    assign ram_bus.req_valid = sys_bus.req_valid && !busy_q && (req_sel == SEL_RAM);
    assign ram_bus.req_addr  = sys_bus.req_addr;
    assign ram_bus.req_wdata = sys_bus.req_wdata;
    assign ram_bus.req_we    = sys_bus.req_we;

    assign sys_bus.req_ready = !busy_q &&
        ((req_sel == SEL_TIMER) ? timer_bus.req_ready : ram_bus.req_ready);

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy_q <= 1'b0;
            sel_q  <= SEL_RAM;
        end else if (sys_bus.req_valid && sys_bus.req_ready) begin
            busy_q <= 1'b1;
            sel_q  <= req_sel;
        end else if (sys_bus.rsp_valid) begin
            busy_q <= 1'b0;
        end
    end

    // response mux follows the latched selection
    assign sys_bus.rsp_valid = busy_q &&
        ((sel_q == SEL_TIMER) ? timer_bus.rsp_valid : ram_bus.rsp_valid);
    assign sys_bus.rsp_rdata = (sel_q == SEL_TIMER) ? timer_bus.rsp_rdata : ram_bus.rsp_rdata;

    // a slave that was not picked stays quiet
    a_only_selected_rsp: assert property (
        @(posedge clk) disable iff (i_reset)
        (timer_bus.rsp_valid |-> busy_q && sel_q == SEL_TIMER) and
        (ram_bus.rsp_valid |-> busy_q && sel_q == SEL_RAM)
    );

endmodule

`default_nettype wire

// ==== hw/bus_arbiter.sv ====
// two-requester bus arbiter
// data port has priority, grant held until the response
// instruction words picked out of the 64-bit response
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module bus_arbiter import soc_pkg::*; (
    input  wire logic  clk,
    input  wire logic  i_reset,
    // instruction fetch port, read only
    input  wire logic  i_inst_valid,
    input  wire addr_t i_inst_addr,
    output logic       o_inst_ready,
    output logic       o_inst_rsp_valid,
    output inst_t      o_inst_rsp_data,
    // data port
    input  wire logic  i_data_valid,
    input  wire addr_t i_data_addr,
    input  wire data_t i_data_wdata,
    input  wire logic  i_data_we,
    output logic       o_data_ready,
    output logic       o_data_rsp_valid,
    output data_t      o_data_rsp_data,
    mem_bus_if.master  sys_bus
);

    logic busy_q;
    logic owner_data_q;
    logic inst_hi_q;
    logic pick_data;
    logic accept;

    // data wins when both ask in the same cycle
    assign pick_data = i_data_valid;

    assign sys_bus.req_valid = !busy_q && (i_data_valid || i_inst_valid);
    assign sys_bus.req_addr  = pick_data ? i_data_addr : i_inst_addr;
    assign sys_bus.req_wdata = pick_data ? i_data_wdata : '0;
    assign sys_bus.req_we    = pick_data && i_data_we;

    assign accept = sys_bus.req_valid && sys_bus.req_ready;

    // loser sees ready low until the winner's response
    assign o_data_ready = !busy_q && sys_bus.req_ready;
    assign o_inst_ready = !busy_q && !i_data_valid && sys_bus.req_ready;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            busy_q       <= 1'b0;
            owner_data_q <= 1'b0;
        end else if (accept) begin
            busy_q       <= 1'b1;
            owner_data_q <= pick_data;
        end else if (sys_bus.rsp_valid) begin
            busy_q <= 1'b0;
        end
    end

    // which half of the doubleword the fetch wants
    always_ff @(posedge clk) begin
        if (accept) begin
            inst_hi_q <= i_inst_addr[2];
        end
    end

    // response goes back to whoever holds the grant
    assign o_data_rsp_valid = sys_bus.rsp_valid && busy_q && owner_data_q;
    assign o_inst_rsp_valid = sys_bus.rsp_valid && busy_q && !owner_data_q;
    assign o_data_rsp_data  = sys_bus.rsp_rdata;
    assign o_inst_rsp_data  = inst_hi_q ? sys_bus.rsp_rdata[`SOC_DATA_W-1 -: `SOC_INST_W]
                                        : sys_bus.rsp_rdata[`SOC_INST_W-1:0];

    // the fabric only answers a transaction this arbiter granted
    a_rsp_needs_grant: assert property (
        @(posedge clk) disable iff (i_reset) sys_bus.rsp_valid |-> busy_q
    );

endmodule

`default_nettype wire

// ==== hw/clint_timer.sv ====
// core-local timer
// free-running mtime, mtimecmp and the timer interrupt
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module clint_timer import soc_pkg::*; (
    input  wire logic clk,
    input  wire logic i_reset,
    mem_bus_if.slave  timer_bus,
    output logic      o_timer_intr
);

    data_t mtime_q;
    data_t mtimecmp_q;
    data_t rdata_q;
    logic  rsp_q;
    logic  accept;
    logic  hit_mtime;
    logic  hit_cmp;

    assign accept    = timer_bus.req_valid && timer_bus.req_ready;
    assign hit_mtime = (timer_bus.req_addr == `SOC_MTIME_ADDR);
    assign hit_cmp   = (timer_bus.req_addr == `SOC_MTIMECMP_ADDR);

    // idle unless a response is going out
    assign timer_bus.req_ready = !rsp_q;
    assign timer_bus.rsp_valid = rsp_q;
    assign timer_bus.rsp_rdata = rdata_q;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            mtime_q      <= `SOC_MTIME_RST;
            mtimecmp_q   <= `SOC_MTIMECMP_RST;
            rsp_q        <= 1'b0;
            o_timer_intr <= 1'b0;
        end else begin
            rsp_q        <= accept;
            o_timer_intr <= (mtime_q >= mtimecmp_q);
            // a write to mtime replaces this cycle's increment
            if (accept && timer_bus.req_we && hit_mtime) begin
                mtime_q <= timer_bus.req_wdata;
            end else begin
                mtime_q <= mtime_q + 1'b1;
            end
            if (accept && timer_bus.req_we && hit_cmp) begin
                mtimecmp_q <= timer_bus.req_wdata;
            end
        end
    end

    // read value captured at acceptance, writes answer zero
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= timer_bus.req_we ? '0 :
                       hit_mtime        ? mtime_q :
                       hit_cmp          ? mtimecmp_q : '0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/mem_bus_if.sv ====
// single-beat request/response bus
// master and slave modports
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if import soc_pkg::*; ();

    // request channel
    logic  req_valid;
    addr_t req_addr;
    data_t req_wdata;
    logic  req_we;
    logic  req_ready;

    // one-pulse response
    logic  rsp_valid;
    data_t rsp_rdata;

    modport master (
        output req_valid, req_addr, req_wdata, req_we,
        input  req_ready, rsp_valid, rsp_rdata
    );

    modport slave (
        input  req_valid, req_addr, req_wdata, req_we,
        output req_ready, rsp_valid, rsp_rdata
    );

endinterface

`default_nettype wire

// ==== hw/ram_bridge.sv ====
// bus to external RAM bridge
// one strobe per access and a response two cycles after acceptance
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module ram_bridge import soc_pkg::*; (
    input  wire logic  clk,
    input  wire logic  i_reset,
    mem_bus_if.slave   ram_bus,
    output logic       o_ram_read_ena,
    output logic       o_ram_write_ena,
    output addr_t      o_ram_addr,
    output data_t      o_ram_wdata,
    input  wire data_t i_ram_rdata
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ACCESS,
        ST_RESPOND
    } state_e;

    state_e state_q;
    addr_t  addr_q;
    data_t  wdata_q;
    logic   we_q;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state_q <= ST_IDLE;
        end else begin
            case (state_q)
                ST_IDLE:    if (ram_bus.req_valid) state_q <= ST_ACCESS;
                ST_ACCESS:  state_q <= ST_RESPOND;
                ST_RESPOND: state_q <= ST_IDLE;
                default:    state_q <= ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == ST_IDLE && ram_bus.req_valid) begin
            addr_q  <= ram_bus.req_addr;
            wdata_q <= ram_bus.req_wdata;
            we_q    <= ram_bus.req_we;
        end
    end

    assign ram_bus.req_ready = (state_q == ST_IDLE);

    // strobes live in the access cycle only
    assign o_ram_read_ena  = (state_q == ST_ACCESS) && !we_q;
    assign o_ram_write_ena = (state_q == ST_ACCESS) && we_q;
    assign o_ram_addr      = addr_q;
    assign o_ram_wdata     = wdata_q;

    // read data arrives from the RAM in the respond cycle
    assign ram_bus.rsp_valid = (state_q == ST_RESPOND);
    assign ram_bus.rsp_rdata = we_q ? '0 : i_ram_rdata;

    a_strobes_exclusive: assert property (
        @(posedge clk) disable iff (i_reset) !(o_ram_read_ena && o_ram_write_ena)
    );

endmodule

`default_nettype wire

// ==== hw/soc_consts.svh ====
// bus and instruction widths
// core-local timer register addresses
// timer reset values
`ifndef SOC_CONSTS_SVH
`define SOC_CONSTS_SVH

// widths fixed by the memory map
`define SOC_ADDR_W 64
`define SOC_DATA_W 64
`define SOC_INST_W 32

// clint register addresses
`define SOC_MTIME_ADDR    64'h0000_0000_0200_BFF8
`define SOC_MTIMECMP_ADDR 64'h0000_0000_0200_4000

// mtime starts at zero
`define SOC_MTIME_RST    64'h0000_0000_0000_0000
// mtimecmp parked at the top so no interrupt after reset
`define SOC_MTIMECMP_RST 64'hFFFF_FFFF_FFFF_FFFF

`endif

// ==== hw/soc_pkg.sv ====
// shared bus types
// address, data and instruction words
// slave select for the address router
`default_nettype none

`include "soc_consts.svh"

package soc_pkg;

    // one bus address
    typedef logic [`SOC_ADDR_W-1:0] addr_t;

    // one bus data word
    typedef logic [`SOC_DATA_W-1:0] data_t;

    // one instruction word
    typedef logic [`SOC_INST_W-1:0] inst_t;

    // target of a routed transaction
    typedef enum logic {
        SEL_RAM   = 1'b0,
        SEL_TIMER = 1'b1
    } slave_sel_e;

endpackage

`default_nettype wire

// ==== hw/soc_top.sv ====
// system side of the SoC
// arbiter, address router, clint timer and RAM bridge
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module soc_top import soc_pkg::*; (
    input  wire logic  clk,
    input  wire logic  i_reset,
    // instruction fetch port
    input  wire logic  i_inst_valid,
    input  wire addr_t i_inst_addr,
    output logic       o_inst_ready,
    output logic       o_inst_rsp_valid,
    output inst_t      o_inst_rsp_data,
    // data port
    input  wire logic  i_data_valid,
    input  wire addr_t i_data_addr,
    input  wire data_t i_data_wdata,
    input  wire logic  i_data_we,
    output logic       o_data_ready,
    output logic       o_data_rsp_valid,
    output data_t      o_data_rsp_data,
    // external RAM
    output logic       o_ram_read_ena,
    output logic       o_ram_write_ena,
    output addr_t      o_ram_addr,
    output data_t      o_ram_wdata,
    input  wire data_t i_ram_rdata,
    output logic       o_timer_intr
);

    mem_bus_if sys_bus ();
    mem_bus_if timer_bus ();
    mem_bus_if ram_bus ();

    bus_arbiter u_bus_arbiter (
        .clk              (clk),
        .i_reset          (i_reset),
        .i_inst_valid     (i_inst_valid),
        .i_inst_addr      (i_inst_addr),
        .o_inst_ready     (o_inst_ready),
        .o_inst_rsp_valid (o_inst_rsp_valid),
        .o_inst_rsp_data  (o_inst_rsp_data),
        .i_data_valid     (i_data_valid),
        .i_data_addr      (i_data_addr),
        .i_data_wdata     (i_data_wdata),
        .i_data_we        (i_data_we),
        .o_data_ready     (o_data_ready),
        .o_data_rsp_valid (o_data_rsp_valid),
        .o_data_rsp_data  (o_data_rsp_data),
        .sys_bus          (sys_bus.master)
    );

    addr_router u_addr_router (
        .clk       (clk),
        .i_reset   (i_reset),
        .sys_bus   (sys_bus.slave),
        .timer_bus (timer_bus.master),
        .ram_bus   (ram_bus.master)
    );

    clint_timer u_clint_timer (
        .clk          (clk),
        .i_reset      (i_reset),
        .timer_bus    (timer_bus.slave),
        .o_timer_intr (o_timer_intr)
    );

    ram_bridge u_ram_bridge (
        .clk             (clk),
        .i_reset         (i_reset),
        .ram_bus         (ram_bus.slave),
        .o_ram_read_ena  (o_ram_read_ena),
        .o_ram_write_ena (o_ram_write_ena),
        .o_ram_addr      (o_ram_addr),
        .o_ram_wdata     (o_ram_wdata),
        .i_ram_rdata     (i_ram_rdata)
    );

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build the SoC testbench with Verilator, run it and check the log
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module tb_soc_top -f filelist.f > build.log 2>&1 \
    || { cat build.log; echo "verilator build failed"; exit 1; }
./obj_dir/Vtb_soc_top > sim.log 2>&1 || echo "simulation exited with an error" >> sim.log
cat sim.log
grep -q "TEST RESULT: FAIL" sim.log && { echo "simulation failed"; exit 1; }
grep -q "TEST RESULT: PASS" sim.log || { echo "no result line in the log"; exit 1; }
echo "simulation passed"

// ==== test/soc_stimulus.txt ====
// port (0 data, 1 fetch, 2 both), op (0 write, 1 read, 2 mtime twice,
// 3 mtimecmp = mtime + data then wait, 4 write then wait), address, data, expected
// expected is the stored doubleword for reads, the interrupt level for ops 3 and 4
0 0 80000000 1122334455667788 0
0 1 80000000 0 1122334455667788
0 0 80000008 cafef00ddeadbeef 0
0 1 80000008 0 cafef00ddeadbeef
1 1 80000008 0 cafef00ddeadbeef
1 1 8000000c 0 cafef00ddeadbeef
1 1 80000000 0 1122334455667788
1 1 80000004 0 1122334455667788
0 0 80000010 0123456789abcdef 0
2 1 80000010 0 0123456789abcdef
2 1 80000014 0 0123456789abcdef
0 0 02004000 0000000012345678 0
0 1 02004000 0 0000000012345678
0 0 0200bff8 0000000000001000 0
0 2 0200bff8 0 0
0 3 02004000 40 1
0 4 02004000 ffffffffffffffff 0
0 1 02004000 0 ffffffffffffffff
f 0 0 0 0

// ==== test/tb_soc_top.sv ====
// testbench for the SoC system side
// clock, reset and a behavioral RAM on the external ports
// stimulus file reader, one compare task, result summary
`timescale 1ns/1ps
`default_nettype none

`include "soc_consts.svh"

module tb_soc_top import soc_pkg::*; ();

    localparam int STIM_WORDS   = 5 * 32;
    localparam int ACCESS_LIMIT = 20;
    localparam int INTR_LIMIT   = 200;

    logic  clk;
    logic  i_reset;
    logic  i_inst_valid;
    addr_t i_inst_addr;
    logic  o_inst_ready;
    logic  o_inst_rsp_valid;
    inst_t o_inst_rsp_data;
    logic  i_data_valid;
    addr_t i_data_addr;
    data_t i_data_wdata;
    logic  i_data_we;
    logic  o_data_ready;
    logic  o_data_rsp_valid;
    data_t o_data_rsp_data;
    logic  o_ram_read_ena;
    logic  o_ram_write_ena;
    addr_t o_ram_addr;
    data_t o_ram_wdata;
    data_t i_ram_rdata = '0;
    logic  o_timer_intr;

    // behavioral RAM with one doubleword per entry
    data_t ram_mem [0:255];
    int    ram_reads = 0;
    int    ram_writes = 0;
    addr_t last_waddr = '0;
    data_t last_wdata = '0;

    logic [63:0] stim [0:STIM_WORDS-1];
    int          checks = 0;
    int          errors = 0;
    int          timeouts = 0;

    soc_top u_soc_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // read data comes back on the cycle after the strobe
    always @(posedge clk) begin
        if (o_ram_read_ena) begin
            i_ram_rdata <= ram_mem[o_ram_addr[10:3]];
            ram_reads   <= ram_reads + 1;
        end
        if (o_ram_write_ena) begin
            ram_mem[o_ram_addr[10:3]] <= o_ram_wdata;
            ram_writes <= ram_writes + 1;
            last_waddr <= o_ram_addr;
            last_wdata <= o_ram_wdata;
        end
    end

    task automatic check(input string name, input data_t exp, input data_t act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("error %s expected %h actual %h", name, exp, act);
        end
    endtask

    function automatic logic is_timer(input addr_t addr);
        return addr == `SOC_MTIME_ADDR || addr == `SOC_MTIMECMP_ADDR;
    endfunction

    // drives one access on either port or both and returns data and response cycles
    task automatic run_access(
        input  logic  use_data,
        input  logic  use_inst,
        input  logic  we,
        input  addr_t addr,
        input  data_t wdata,
        output data_t d_rsp,
        output inst_t i_rsp,
        output int    d_at,
        output int    i_at
    );
        logic d_pend;
        logic i_pend;
        logic d_wait;
        logic i_wait;
        logic d_go;
        logic i_go;
        int   cyc;
        d_rsp  = '0;
        i_rsp  = '0;
        d_at   = -1;
        i_at   = -1;
        d_pend = use_data;
        i_pend = use_inst;
        d_wait = use_data;
        i_wait = use_inst;
        cyc    = 0;
        @(posedge clk);
        i_data_valid <= use_data;
        i_data_addr  <= addr;
        i_data_wdata <= wdata;
        i_data_we    <= we;
        i_inst_valid <= use_inst;
        i_inst_addr  <= addr;
        while ((d_wait || i_wait) && cyc < ACCESS_LIMIT) begin
            @(negedge clk);
            d_go = d_pend && o_data_ready;
            i_go = i_pend && o_inst_ready;
            if (d_wait && o_data_rsp_valid) begin
                d_rsp  = o_data_rsp_data;
                d_at   = cyc;
                d_wait = 1'b0;
            end
            if (i_wait && o_inst_rsp_valid) begin
                i_rsp  = o_inst_rsp_data;
                i_at   = cyc;
                i_wait = 1'b0;
            end
            @(posedge clk);
            // request transferred on this edge
            if (d_go) begin
                i_data_valid <= 1'b0;
                d_pend = 1'b0;
            end
            if (i_go) begin
                i_inst_valid <= 1'b0;
                i_pend = 1'b0;
            end
            cyc++;
        end
        if (d_wait || i_wait) begin
            timeouts++;
            $display("timeout: no response to the access at %h within %0d cycles",
                     addr, ACCESS_LIMIT);
            i_data_valid <= 1'b0;
            i_inst_valid <= 1'b0;
        end
    endtask

    task automatic wait_intr(input logic level);
        int cyc;
        cyc = 0;
        @(negedge clk);
        while (o_timer_intr !== level && cyc < INTR_LIMIT) begin
            @(negedge clk);
            cyc++;
        end
        if (o_timer_intr !== level) begin
            timeouts++;
            $display("timeout: timer interrupt did not go to %0d within %0d cycles",
                     level, INTR_LIMIT);
        end
    endtask

    // one line of the stimulus file
    task automatic run_line(
        input logic [3:0] port,
        input logic [3:0] op,
        input addr_t      addr,
        input data_t      wdata,
        input data_t      exp
    );
        data_t d_rsp;
        data_t mt0;
        inst_t i_rsp;
        int    d_at;
        int    i_at;
        int    rd0;
        int    wr0;
        rd0 = ram_reads;
        wr0 = ram_writes;
        case (op)
            4'd0: begin
                run_access(1'b1, 1'b0, 1'b1, addr, wdata, d_rsp, i_rsp, d_at, i_at);
                check("write response", exp, d_rsp);
            end
            4'd1: begin
                run_access(port != 4'd1, port != 4'd0, 1'b0, addr, '0,
                           d_rsp, i_rsp, d_at, i_at);
                if (port != 4'd1) check("data read", exp, d_rsp);
                // fetch picks a half of the doubleword by address bit 2
                if (port != 4'd0) begin
                    check("instruction fetch", 64'(addr[2] ? exp[63:32] : exp[31:0]),
                          64'(i_rsp));
                end
                if (port == 4'd2) check("data before instruction", 64'h1, 64'(d_at < i_at));
            end
            4'd2: begin
                run_access(1'b1, 1'b0, 1'b0, addr, '0, mt0, i_rsp, d_at, i_at);
                run_access(1'b1, 1'b0, 1'b0, addr, '0, d_rsp, i_rsp, d_at, i_at);
                check("mtime increasing", 64'h1, 64'(d_rsp > mt0));
            end
            4'd3: begin
                run_access(1'b1, 1'b0, 1'b0, `SOC_MTIME_ADDR, '0, mt0, i_rsp, d_at, i_at);
                run_access(1'b1, 1'b0, 1'b1, addr, mt0 + wdata, d_rsp, i_rsp, d_at, i_at);
                @(negedge clk);
                check("interrupt before compare", 64'h0, 64'(o_timer_intr));
                wait_intr(exp[0]);
            end
            4'd4: begin
                run_access(1'b1, 1'b0, 1'b1, addr, wdata, d_rsp, i_rsp, d_at, i_at);
                check("write response", 64'h0, d_rsp);
                wait_intr(exp[0]);
            end
            default: begin
                errors++;
                $display("stimulus line has an unknown operation %0d", op);
            end
        endcase
        if (is_timer(addr)) begin
            check("no RAM read for timer", 64'(rd0), 64'(ram_reads));
            check("no RAM write for timer", 64'(wr0), 64'(ram_writes));
        end else if (op == 4'd0) begin
            check("one RAM write strobe", 64'(wr0 + 1), 64'(ram_writes));
            check("RAM write address", addr, last_waddr);
            check("RAM write data", wdata, last_wdata);
        end
    endtask

    initial begin
        void'($urandom(78));
        i_reset      = 1'b1;
        i_inst_valid = 1'b0;
        i_inst_addr  = '0;
        i_data_valid = 1'b0;
        i_data_addr  = '0;
        i_data_wdata = '0;
        i_data_we    = 1'b0;
        // unread entries end the run
        foreach (stim[k]) stim[k] = '1;
        $readmemh("test/soc_stimulus.txt", stim);
        repeat (2) @(posedge clk);
        i_reset <= 1'b0;
        @(negedge clk);
        check("inst response after reset", 64'h0, 64'(o_inst_rsp_valid));
        check("data response after reset", 64'h0, 64'(o_data_rsp_valid));
        check("read strobe after reset", 64'h0, 64'(o_ram_read_ena));
        check("write strobe after reset", 64'h0, 64'(o_ram_write_ena));
        check("interrupt after reset", 64'h0, 64'(o_timer_intr));
        for (int idx = 0; idx < STIM_WORDS; idx += 5) begin
            if (stim[idx][3:0] == 4'hf) break;
            run_line(stim[idx][3:0], stim[idx+1][3:0], stim[idx+2], stim[idx+3], stim[idx+4]);
            repeat ($urandom_range(3, 0)) @(posedge clk);
        end
        $display("checks: %0d, errors: %0d, timeouts: %0d", checks, errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    // overall limit on the run
    initial begin
        repeat (20000) @(posedge clk);
        $display("timeout: simulation did not finish within 20000 cycles");
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire
